// File: la_capture.f
src/la_pkg.sv
src/mem_if.sv
src/rd_stream_if.sv
src/capture_ctrl.sv
src/sample_ram.sv
src/tx_credit_out.sv
src/la_capture_top.sv
sim/la_capture_properties.sv
sim/la_capture_checker.sv
sim/la_capture_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= la_capture_tb
FILELIST  ?= la_capture.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run the simulation, check $(LOG)"
	@echo "  clean  remove $(OBJ_DIR) and $(LOG)"
	@echo "variables: VERILATOR TOP FILELIST OBJ_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "TEST RESULT: FAIL" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q "TEST RESULT: PASS" $(LOG); then echo "simulation gave no verdict"; exit 1; fi
	@echo "simulation passed"

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: sim/la_capture_tb.sv
// logic analyzer capture testbench
module la_capture_tb;

  localparam int DEPTH      = 16;
  localparam int TX_CREDITS = 4;
  localparam int N_ROWS     = 8;
  localparam int N_COLS     = 7;
  localparam int C_DLY      = 0;
  localparam int C_RD       = 1;
  localparam int C_PRE      = 2;
  localparam int C_GAP      = 3;
  localparam int C_CDLY     = 4;
  localparam int C_SET      = 5;
  localparam int C_XTRA     = 6;

  logic          clk_i;
  logic          rst_in;
  logic          set_cnt_i;
  la_pkg::cmd_t  cmd_i;
  logic          run_i;
  logic          stb_i;
  la_pkg::smpl_t smpl_i;
  logic          credit_i;
  logic          busy_o;
  logic          tx_valid_o;
  logic          tx_last_o;
  la_pkg::smpl_t tx_data_o;

  logic note;           // strobe expected to be captured
  logic arm;
  int   arm_len;
  int   last_rd = 1;    // read count after reset
  int   cur_cdly = 0;
  int   seed;
  int   err_cnt;

  // delay, read, pre-trigger, gap, credit delay, send command, strobes in readout
  int scen [N_ROWS][N_COLS] = '{
    '{1,  1,  0, 0,  0, 0, 0},  // defaults after reset
    '{3,  8,  6, 1,  0, 1, 0},  // pre-trigger history in burst
    '{4, 20, 10, 0,  1, 1, 2},  // clamp to DEPTH, wraps the ring
    '{2, 12,  6, 0, 12, 1, 0},  // slow credit return
    '{5,  6,  3, 2,  2, 1, 4},  // strobes dropped in readout
    '{1, 10,  2, 0,  0, 1, 0},  // burst spans the dropped strobes
    '{2,  0,  1, 0,  0, 1, 0},  // zero read count
    '{2,  5,  3, 1,  3, 1, 3}
  };

  la_capture_top #(.DEPTH(DEPTH), .TX_CREDITS(TX_CREDITS)) dut (
    .clk_i, .rst_in, .set_cnt_i, .cmd_i, .run_i, .stb_i, .smpl_i, .credit_i,
    .busy_o, .tx_valid_o, .tx_last_o, .tx_data_o
  );

  la_capture_checker #(.DEPTH(DEPTH), .TX_CREDITS(TX_CREDITS)) chk (
    .clk_i, .rst_in, .stb_i, .smpl_i, .note_i(note), .arm_i(arm), .arm_len_i(arm_len),
    .busy_i(busy_o), .tx_valid_i(tx_valid_o), .tx_last_i(tx_last_o),
    .tx_data_i(tx_data_o), .credit_i, .err_cnt_o(err_cnt)
  );

  initial begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  task automatic tick();
    @(posedge clk_i);
    #1;
  endtask

  function automatic int timeout_cycles();
    int sum;
    int r;
    sum = 200;  // reset and margin
    for (r = 0; r < N_ROWS; r++) begin
      sum += (scen[r][C_PRE] + scen[r][C_DLY] + scen[r][C_XTRA] + scen[r][C_RD])
             * (scen[r][C_GAP] + scen[r][C_CDLY] + 4);
    end
    return sum;
  endfunction

  task automatic strobe(input logic keep, input int gap);
    smpl_i = $random(seed);
    stb_i  = 1'b1;
    note   = keep;
    tick();
    stb_i  = 1'b0;
    note   = 1'b0;
    repeat (gap) tick();
  endtask

  task automatic send_command(input int rd, input int dly);
    cmd_i     = {16'(rd), 16'(dly)};
    set_cnt_i = 1'b1;
    tick();
    set_cnt_i = 1'b0;
  endtask

  task automatic trigger(input int rd_len);
    run_i   = 1'b1;
    arm     = 1'b1;
    arm_len = rd_len;
    tick();
    run_i   = 1'b0;
    arm     = 1'b0;
  endtask

  task automatic run_row(input int r);
    int i;
    cur_cdly = scen[r][C_CDLY];
    if (scen[r][C_SET] != 0) begin
      send_command(scen[r][C_RD], scen[r][C_DLY]);
      last_rd = scen[r][C_RD];
    end
    for (i = 0; i < scen[r][C_PRE]; i++) begin
      strobe(1'b1, scen[r][C_GAP]);
    end
    trigger(last_rd);
    for (i = 0; i < scen[r][C_DLY]; i++) begin
      strobe(1'b1, scen[r][C_GAP]);
    end
    i = 0;
    while (i < scen[r][C_XTRA] && busy_o) begin  // only while reading out
      strobe(1'b0, 0);
      i++;
    end
    while (busy_o) tick();
    tick();
  endtask

  // returns one credit per word after the row's delay
  initial begin : credit_return
    int due_q [$];
    int cyc;
    credit_i = 1'b0;
    cyc      = 0;
    forever begin
      @(negedge clk_i);
      if (tx_valid_o) begin
        due_q.push_back(cyc + cur_cdly + 1);
      end
      @(posedge clk_i);
      #1;
      cyc++;
      credit_i = 1'b0;
      if (due_q.size() > 0 && due_q[0] <= cyc) begin
        credit_i = 1'b1;
        void'(due_q.pop_front());
      end
    end
  end

  initial begin : watchdog
    int limit;
    int cycle_cnt;
    limit     = timeout_cycles();
    cycle_cnt = 0;
    while (cycle_cnt < limit) begin
      @(posedge clk_i);
      cycle_cnt++;
    end
    $display("ERROR: run did not finish within %0d cycles", limit);
    $display("TEST RESULT: FAIL");
    $finish;
  end

  initial begin : stimulus
    int r;
    seed      = 91;
    rst_in    = 1'b0;
    set_cnt_i = 1'b0;
    cmd_i     = '0;
    run_i     = 1'b0;
    stb_i     = 1'b0;
    smpl_i    = '0;
    note      = 1'b0;
    arm       = 1'b0;
    arm_len   = 1;
    repeat (10) tick();
    rst_in = 1'b1;
    repeat (2) tick();
    for (r = 0; r < N_ROWS; r++) begin
      run_row(r);
    end
    repeat (4) tick();
    $display("checker errors: %0d, assertion failures: %0d", err_cnt, dut.u_props.fail_cnt);
    if (err_cnt == 0 && dut.u_props.fail_cnt == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

// File: sim/la_capture_checker.sv
// burst reference model and checker
module la_capture_checker #(
  parameter int DEPTH      = 16,
  parameter int TX_CREDITS = 4
) (
  input  logic          clk_i,
  input  logic          rst_in,
  input  logic          stb_i,
  input  la_pkg::smpl_t smpl_i,
  input  logic          note_i,     // this strobe is captured
  input  logic          arm_i,      // run issued
  input  int            arm_len_i,  // read count in force
  input  logic          busy_i,
  input  logic          tx_valid_i,
  input  logic          tx_last_i,
  input  la_pkg::smpl_t tx_data_i,
  input  logic          credit_i,
  output int            err_cnt_o
);

  la_pkg::smpl_t hist [$];  // captured samples, oldest first
  int   exp_len;
  int   got_cnt;
  int   in_flight;  // words sent minus credits returned
  logic armed;
  logic rise_pend;
  logic busy_q;
  logic fresh;      // first cycle out of reset

  task automatic check_word();
    int   pos;
    logic exp_last;
    pos      = hist.size() - exp_len + got_cnt;  // newest exp_len samples
    exp_last = (got_cnt == exp_len - 1);
    if (pos < 0) begin
      $display("ERROR: burst of %0d words needs more samples than were captured", exp_len);
      err_cnt_o++;
    end else begin
      if (tx_data_i !== hist[pos]) begin
        $display("MISMATCH tx_data_o: expected %08h, got %08h (word %0d)",
                 hist[pos], tx_data_i, got_cnt);
        err_cnt_o++;
      end
      if (tx_last_i !== exp_last) begin
        $display("MISMATCH tx_last_o: expected %0h, got %0h (word %0d)",
                 exp_last, tx_last_i, got_cnt);
        err_cnt_o++;
      end
    end
  endtask

  // outputs are sampled mid-cycle, away from the rising edge
  always @(negedge clk_i) begin
    if (!rst_in) begin
      hist.delete();
      exp_len   = 0;
      got_cnt   = 0;
      in_flight = 0;
      armed     = 1'b0;
      rise_pend = 1'b0;
      busy_q    = 1'b0;
      fresh     = 1'b1;
      err_cnt_o = 0;
    end else begin
      if (fresh && {busy_i, tx_valid_i, tx_last_i} !== 3'b000) begin
        $display("MISMATCH busy_o/tx_valid_o/tx_last_o after reset: expected 0/0/0, got %0h/%0h/%0h",
                 busy_i, tx_valid_i, tx_last_i);
        err_cnt_o++;
      end
      fresh = 1'b0;
      if (stb_i && note_i) begin
        hist.push_back(smpl_i);
      end
      if (tx_valid_i) begin
        in_flight++;
        if (in_flight > TX_CREDITS) begin
          $display("ERROR: %0d words sent ahead of returned credits", in_flight);
          err_cnt_o++;
        end
        if (!armed) begin
          $display("ERROR: word sent while no burst was expected");
          err_cnt_o++;
        end else if (got_cnt < exp_len) begin
          check_word();
        end
        got_cnt++;
      end
      if (credit_i) begin
        in_flight--;
      end
      if (rise_pend && !busy_i) begin
        $display("ERROR: busy_o did not rise after run");
        err_cnt_o++;
      end
      rise_pend = 1'b0;
      if (armed && busy_q && !busy_i) begin
        if (got_cnt != exp_len) begin
          $display("ERROR: burst length wrong, expected %0d words, got %0d", exp_len, got_cnt);
          err_cnt_o++;
        end
        armed = 1'b0;
      end
      if (arm_i) begin
        exp_len   = (arm_len_i > DEPTH) ? DEPTH : arm_len_i;  // ring holds DEPTH at most
        got_cnt   = 0;
        armed     = 1'b1;
        rise_pend = 1'b1;
      end
      busy_q = busy_i;
    end
  end

endmodule

// File: sim/la_capture_properties.sv
// credit and controller assertions
module la_capture_properties #(
  parameter int TX_CREDITS = 4
) (
  input logic clk_i,
  input logic rst_in,
  input logic tx_valid_i,
  input logic credit_i,    // credit return at the top level
  input logic rd_en_i,
  input logic room_i,
  input logic busy_i,
  input logic empty_i      // output queue holds nothing
);

  int credits_seen;        // receiver's view of the credit count
  int fail_cnt = 0;

  always_ff @(posedge clk_i) begin
    if (!rst_in) begin
      credits_seen <= TX_CREDITS;
    end else begin
      credits_seen <= credits_seen - int'(tx_valid_i) + int'(credit_i);
    end
  end

  a_send_needs_credit : assert property (@(posedge clk_i) disable iff (!rst_in)
    tx_valid_i |-> credits_seen != 0)
    else begin
      $error("tx_valid_o pulsed while no credit was held");
      fail_cnt++;
    end

  // a credit returned now reaches the counter one cycle later
  a_no_second_send : assert property (@(posedge clk_i) disable iff (!rst_in)
    (tx_valid_i && credits_seen == 1) |=> !tx_valid_i)
    else begin
      $error("tx_valid_o high two cycles running without a credit");
      fail_cnt++;
    end

  a_read_with_room : assert property (@(posedge clk_i) disable iff (!rst_in)
    rd_en_i |-> room_i)
    else begin
      $error("rd_en issued while the output queue had no room");
      fail_cnt++;
    end

  a_idle_drained : assert property (@(posedge clk_i) disable iff (!rst_in)
    !busy_i |-> empty_i)
    else begin
      $error("busy_o low while the output queue still held a word");
      fail_cnt++;
    end

endmodule

bind la_capture_top la_capture_properties #(.TX_CREDITS(TX_CREDITS)) u_props (
  .clk_i      (clk_i),
  .rst_in     (rst_in),
  .tx_valid_i (tx_valid_o),
  .credit_i   (credit_i),
  .rd_en_i    (mem_bus.rd_en),
  .room_i     (rs_bus.room),
  .busy_i     (busy_o),
  .empty_i    (rs_bus.empty)
);

// File: src/la_capture_top.sv
// logic analyzer capture core
module la_capture_top #(
  parameter int DEPTH      = 16,
  parameter int TX_CREDITS = 4
) (
  input  logic            clk_i,
  input  logic            rst_in,
  input  logic            set_cnt_i,
  input  la_pkg::cmd_t    cmd_i,
  input  logic            run_i,
  input  logic            stb_i,
  input  la_pkg::smpl_t   smpl_i,
  input  logic            credit_i,
  output logic            busy_o,
  output logic            tx_valid_o,
  output logic            tx_last_o,
  output la_pkg::smpl_t   tx_data_o
);

  mem_if       mem_bus ();
  rd_stream_if rs_bus ();

  capture_ctrl #(.DEPTH(DEPTH)) u_ctrl (
    .clk_i     (clk_i),
    .rst_in    (rst_in),
    .set_cnt_i (set_cnt_i),
    .cmd_i     (cmd_i),
    .run_i     (run_i),
    .stb_i     (stb_i),
    .smpl_i    (smpl_i),
    .mem       (mem_bus.ctrl),
    .rs        (rs_bus.monitor),
    .busy_o    (busy_o)
  );

  sample_ram #(.DEPTH(DEPTH)) u_ram (
    .clk_i  (clk_i),
    .rst_in (rst_in),
    .mem    (mem_bus.mem),
    .rs     (rs_bus.source)
  );

  tx_credit_out #(.TX_CREDITS(TX_CREDITS)) u_out (
    .clk_i      (clk_i),
    .rst_in     (rst_in),
    .credit_i   (credit_i),
    .rs         (rs_bus.sink),
    .tx_valid_o (tx_valid_o),
    .tx_last_o  (tx_last_o),
    .tx_data_o  (tx_data_o)
  );

endmodule

// File: src/tx_credit_out.sv
// credit-controlled output queue
module tx_credit_out #(
  parameter int TX_CREDITS = 4
) (
  input  logic            clk_i,
  input  logic            rst_in,
  input  logic            credit_i,   // one word consumed by receiver
  rd_stream_if.sink       rs,
  output logic            tx_valid_o,
  output logic            tx_last_o,
  output la_pkg::smpl_t   tx_data_o
);

  localparam int CW = $clog2(TX_CREDITS + 1);

  typedef logic [CW-1:0] credit_t;

  la_pkg::smpl_t q_data [2];  // head at index 0
  logic [1:0]    q_last;
  logic [1:0]    fill_q;
  credit_t       credits_q;

  logic push;
  logic send;
  logic wr_idx;

  assign push   = rs.valid;
  assign send   = (fill_q != 2'd0) && (credits_q != '0);
  assign wr_idx = send ? (fill_q == 2'd2) : (fill_q == 2'd1);  // slot after the pop

  // held words plus the one arriving
  assign rs.room  = (fill_q + {1'b0, push}) < 2'd2;
  assign rs.empty = (fill_q == 2'd0) && !push;

  always_ff @(posedge clk_i) begin
    if (send) begin
      q_data[0] <= q_data[1];
      q_last[0] <= q_last[1];
      tx_data_o <= q_data[0];
    end
    if (push) begin
      q_data[wr_idx] <= rs.data;  // overrides the shift when both land in slot 0
      q_last[wr_idx] <= rs.last;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_in) begin
      fill_q     <= 2'd0;
      credits_q  <= credit_t'(TX_CREDITS);
      tx_valid_o <= 1'b0;
      tx_last_o  <= 1'b0;
    end else begin
      fill_q     <= fill_q + {1'b0, push} - {1'b0, send};
      tx_valid_o <= send;
      tx_last_o  <= send & q_last[0];
      case ({credit_i, send})
        2'b10:   credits_q <= credits_q + 1'b1;
        2'b01:   credits_q <= credits_q - 1'b1;
        default: credits_q <= credits_q;  // none, or send and return together
      endcase
    end
  end

endmodule

// File: src/sample_ram.sv
// ring-buffer sample memory
module sample_ram #(
  parameter int DEPTH = 16
) (
  input  logic          clk_i,
  input  logic          rst_in,
  mem_if.mem            mem,
  rd_stream_if.source   rs
);

  localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;

  typedef logic [AW-1:0] addr_t;

  la_pkg::smpl_t ram [DEPTH];

  addr_t wr_ptr;
  addr_t rd_ptr;
  addr_t start_ptr;

  function automatic addr_t ptr_inc(addr_t p);
    if (p == addr_t'(DEPTH - 1)) begin
      return '0;
    end
    return p + 1'b1;
  endfunction

  // oldest word of the burst, write pointer minus rd_len mod DEPTH
  always_comb begin : start_calc
    int unsigned ofs;
    ofs = int'(wr_ptr) + DEPTH - int'(mem.rd_len);
    if (ofs >= DEPTH) begin
      ofs = ofs - DEPTH;
    end
    start_ptr = addr_t'(ofs);
  end

  always_ff @(posedge clk_i) begin
    if (!rst_in) begin
      wr_ptr   <= '0;
      rd_ptr   <= '0;
      rs.valid <= 1'b0;
      rs.last  <= 1'b0;
    end else begin
      if (mem.wr_en) begin
        wr_ptr <= ptr_inc(wr_ptr);
      end
      if (mem.rd_start) begin
        rd_ptr <= start_ptr;
      end else if (mem.rd_en) begin
        rd_ptr <= ptr_inc(rd_ptr);
      end
      rs.valid <= mem.rd_en;
      rs.last  <= mem.rd_en & mem.rd_last;
    end
  end

  always_ff @(posedge clk_i) begin
    if (mem.wr_en) begin
      ram[wr_ptr] <= mem.wr_data;
    end
    if (mem.rd_en) begin
      rs.data <= ram[rd_ptr];  // registered read port
    end
  end

endmodule

// File: src/capture_ctrl.sv
// capture and readout controller
module capture_ctrl #(
  parameter int DEPTH = 16
) (
  input  logic              clk_i,
  input  logic              rst_in,
  input  logic              set_cnt_i,  // load counts from cmd_i
  input  la_pkg::cmd_t      cmd_i,
  input  logic              run_i,      // trigger
  input  logic              stb_i,      // sample strobe
  input  la_pkg::smpl_t     smpl_i,
  mem_if.ctrl               mem,
  rd_stream_if.monitor      rs,
  output logic              busy_o
);

  localparam la_pkg::cnt_t MAX_RD = la_pkg::cnt_t'(DEPTH);

  la_pkg::ctrl_state_t state_q, state_d;

  la_pkg::cnt_t rd_cnt_q;   // words to send, clamped to DEPTH
  la_pkg::cnt_t dly_cnt_q;  // post-trigger writes
  la_pkg::cnt_t post_q, post_d;
  la_pkg::cnt_t idx_q, idx_d;
  logic         started_q, started_d;  // rd_start already issued

  la_pkg::cnt_t cmd_rd;

  assign cmd_rd = cmd_i[31:16];

  always_ff @(posedge clk_i) begin
    if (!rst_in) begin
      rd_cnt_q  <= la_pkg::cnt_t'(1);
      dly_cnt_q <= la_pkg::cnt_t'(1);
    end else if (set_cnt_i) begin
      rd_cnt_q  <= (cmd_rd > MAX_RD) ? MAX_RD : cmd_rd;  // never more than the ring holds
      dly_cnt_q <= cmd_i[15:0];
    end
  end

  assign mem.wr_data = smpl_i;
  assign mem.rd_len  = rd_cnt_q;

  always_comb begin
    state_d      = state_q;
    post_d       = post_q;
    idx_d        = idx_q;
    started_d    = started_q;
    mem.wr_en    = 1'b0;
    mem.rd_start = 1'b0;
    mem.rd_en    = 1'b0;
    mem.rd_last  = 1'b0;

    case (state_q)
      la_pkg::IDLE: begin
        mem.wr_en = stb_i;  // keep pre-trigger history
        if (run_i) begin
          state_d = la_pkg::TRIGGERED;
          post_d  = '0;
        end
      end

      la_pkg::TRIGGERED: begin
        if (run_i) begin
          mem.wr_en = stb_i;  // restart, this strobe counts as history
          post_d    = '0;
        end else if (post_q >= dly_cnt_q) begin
          state_d   = la_pkg::READOUT;  // zero delay
          started_d = 1'b0;
        end else if (stb_i) begin
          mem.wr_en = 1'b1;
          post_d    = post_q + 1'b1;
          if (la_pkg::cnt_t'(post_q + 1'b1) == dly_cnt_q) begin
            state_d   = la_pkg::READOUT;
            started_d = 1'b0;
          end
        end
      end

      la_pkg::READOUT: begin
        if (!started_q) begin
          if (rd_cnt_q == '0) begin
            state_d = la_pkg::IDLE;  // nothing to send
          end else begin
            mem.rd_start = 1'b1;
            started_d    = 1'b1;
            idx_d        = '0;
          end
        end else if (rs.room) begin
          mem.rd_en   = 1'b1;
          mem.rd_last = (idx_q == la_pkg::cnt_t'(rd_cnt_q - 1'b1));
          idx_d       = idx_q + 1'b1;
          if (mem.rd_last) begin
            state_d = la_pkg::DRAIN;
          end
        end
      end

      la_pkg::DRAIN: begin
        if (rs.empty) begin
          state_d = la_pkg::IDLE;
        end
      end

      default: state_d = la_pkg::IDLE;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (!rst_in) begin
      state_q   <= la_pkg::IDLE;
      post_q    <= '0;
      idx_q     <= '0;
      started_q <= 1'b0;
    end else begin
      state_q   <= state_d;
      post_q    <= post_d;
      idx_q     <= idx_d;
      started_q <= started_d;
    end
  end

  assign busy_o = (state_q != la_pkg::IDLE);

endmodule

// File: src/rd_stream_if.sv
// read data stream from memory to output stage
interface rd_stream_if;

  logic           valid;  // word present, one cycle after rd_en
  la_pkg::smpl_t  data;
  logic           last;   // tag of the final word
  logic           room;   // space for one more read
  logic           empty;  // nothing held and nothing arriving

  modport source (output valid, data, last);

  modport sink (
    input  valid, data, last,
    output room, empty
  );

  modport monitor (input room, empty);

endinterface

// File: src/mem_if.sv
// controller to sample memory link
interface mem_if;

  logic           wr_en;     // write one sample this cycle
  la_pkg::smpl_t  wr_data;   // sample to store
  logic           rd_start;  // load read pointer
  la_pkg::cnt_t   rd_len;    // words back from write pointer
  logic           rd_en;     // read one word, advance pointer
  logic           rd_last;   // final read of the burst

  modport ctrl (
    output wr_en, wr_data,
    output rd_start, rd_len,
    output rd_en, rd_last
  );

  modport mem (
    input wr_en, wr_data,
    input rd_start, rd_len,
    input rd_en, rd_last
  );

endinterface

// File: src/la_pkg.sv
// logic analyzer shared types
package la_pkg;

  // one captured sample
  typedef logic [31:0] smpl_t;

  // count decoded from half of the command word
  typedef logic [15:0] cnt_t;

  // command word: read count in the upper half, post-trigger delay in the lower half
  typedef logic [31:0] cmd_t;

  // capture and readout states
  typedef enum logic [1:0] {
    IDLE,       // pre-trigger capture
    TRIGGERED,  // counting post-trigger writes
    READOUT,    // issuing reads
    DRAIN       // waiting for output queue to empty
  } ctrl_state_t;

endpackage
